// ==== Bender.yml ====
package:
  name: npu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/npu_pkg.sv
      - verilog/npu_apb_port.sv
      - verilog/npu_scratch_mem.sv
      - verilog/npu_operand_feeder.sv
      - verilog/npu_pe.sv
      - verilog/npu_systolic_array.sv
      - verilog/npu_result_writer.sv
      - verilog/npu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/npu_tb.sv

// ==== bench/npu_tb.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_tb;

    localparam int NUM_CASES = 8;
    localparam int CYCLE_LIMIT = 250 * (NUM_CASES + 2); // Memory test counts as two entries
    localparam logic [1:0] FILL_RAND = 2'd0;
    localparam logic [1:0] FILL_IDENT = 2'd1;
    localparam logic [1:0] FILL_ONES = 2'd2;

    typedef struct packed {
        npu_pkg::npu_addr_t src1;
        npu_pkg::npu_addr_t src2;
        npu_pkg::npu_addr_t dst;
        logic [1:0] kind; // Fill of B, A is always random
        logic err; // Refused accesses while busy
    } case_t;

    logic clk_50 = 1'b0;
    logic rst;
    logic psel, penable, pwrite;
    logic [11:0] paddr;
    npu_pkg::npu_word_t pwdata, prdata;
    logic pready, pslverr, irq;

    case_t cases [NUM_CASES];
    string case_names [NUM_CASES];
    npu_pkg::npu_word_t ref_mem [`NPU_MEM_WORDS]; // Expected memory contents
    npu_pkg::npu_word_t exp_tile [`NPU_DIM*`NPU_DIM];
    npu_pkg::npu_word_t lcg_state;
    npu_pkg::npu_word_t rd;
    int cycle_count = 0;

    npu_top i_npu_top (
        .clk_50  (clk_50),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #2 clk_50 = ~clk_50;

    always @(posedge clk_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    // ********************
    // Helpers and checks
    // ********************
    function automatic npu_pkg::npu_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic npu_pkg::npu_addr_t wrap_addr(npu_pkg::npu_addr_t base, int k);
        return base + npu_pkg::npu_addr_t'(k); // Modulo memory depth
    endfunction

    function automatic logic [11:0] byte_addr(npu_pkg::npu_addr_t a);
        return 12'(a) << 2;
    endfunction

    function automatic npu_pkg::npu_status_t status_of(logic busy, logic done, logic error);
        npu_pkg::npu_status_t st;
        st.busy = busy;
        st.done = done;
        st.error = error;
        return st;
    endfunction

    task automatic check_word(input string name, input npu_pkg::npu_word_t exp,
                              input npu_pkg::npu_word_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_status(input string name, input npu_pkg::npu_status_t exp,
                                input npu_pkg::npu_status_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected status %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Status mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected pslverr %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Slave error mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected pready %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Ready mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected irq %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "Interrupt mismatch");
        end
    endtask

    // ********************
    // APB transfers
    // ********************
    task automatic apb_write(input string name, input logic [11:0] addr,
                             input npu_pkg::npu_word_t data, input logic exp_err);
        logic err;
        logic rdy;
        @(negedge clk_50);
        psel = 1'b1; // Setup phase
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk_50);
        penable = 1'b1;
        #1;
        err = pslverr;
        rdy = pready;
        @(negedge clk_50);
        psel = 1'b0;
        penable = 1'b0;
        check_ready(name, 1'b1, rdy); // Zero wait states
        check_err(name, exp_err, err);
    endtask

    task automatic apb_read(input string name, input logic [11:0] addr, input logic exp_err,
                            output npu_pkg::npu_word_t data);
        logic err;
        logic rdy;
        @(negedge clk_50);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk_50);
        penable = 1'b1;
        #1;
        err = pslverr; // Mid access phase
        rdy = pready;
        data = prdata;
        @(negedge clk_50);
        psel = 1'b0;
        penable = 1'b0;
        check_ready(name, 1'b1, rdy);
        check_err(name, exp_err, err);
    endtask

    // C = A*B modulo 2^32, results land in the model memory afterwards
    task automatic compute_ref(input case_t tc);
        npu_pkg::npu_word_t sum;
        for (int r = 0; r < `NPU_DIM; r++) begin
            for (int c = 0; c < `NPU_DIM; c++) begin
                sum = '0;
                for (int j = 0; j < `NPU_DIM; j++) begin
                    sum = sum + ref_mem[wrap_addr(tc.src1, `NPU_DIM * r + j)]
                              * ref_mem[wrap_addr(tc.src2, `NPU_DIM * j + c)];
                end
                exp_tile[`NPU_DIM * r + c] = sum;
            end
        end
        for (int k = 0; k < `NPU_DIM * `NPU_DIM; k++) begin
            ref_mem[wrap_addr(tc.dst, k)] = exp_tile[k];
        end
    endtask

    task automatic set_case(input int i, input string name, input int s1, input int s2,
                            input int d, input logic [1:0] kind, input logic err);
        case_names[i] = name;
        cases[i].src1 = npu_pkg::npu_addr_t'(s1);
        cases[i].src2 = npu_pkg::npu_addr_t'(s2);
        cases[i].dst = npu_pkg::npu_addr_t'(d);
        cases[i].kind = kind;
        cases[i].err = err;
    endtask

    task automatic run_case(input int i);
        case_t tc;
        string nm;
        npu_pkg::npu_addr_t a;
        npu_pkg::npu_word_t data;
        npu_pkg::npu_status_t st;
        tc = cases[i];
        nm = case_names[i];
        for (int k = 0; k < `NPU_DIM * `NPU_DIM; k++) begin
            a = wrap_addr(tc.src1, k);
            ref_mem[a] = lcg_next();
            apb_write(nm, byte_addr(a), ref_mem[a], 1'b0);
        end
        for (int k = 0; k < `NPU_DIM * `NPU_DIM; k++) begin
            a = wrap_addr(tc.src2, k);
            case (tc.kind)
                FILL_IDENT: ref_mem[a] = (k % (`NPU_DIM + 1) == 0) ? 32'd1 : 32'd0;
                FILL_ONES: ref_mem[a] = 32'd1;
                default: ref_mem[a] = lcg_next();
            endcase
            apb_write(nm, byte_addr(a), ref_mem[a], 1'b0); // May overwrite A on overlap
        end
        apb_write(nm, `NPU_REG_SRC1, 32'(tc.src1), 1'b0);
        apb_write(nm, `NPU_REG_SRC2, 32'(tc.src2), 1'b0);
        apb_write(nm, `NPU_REG_DST, 32'(tc.dst), 1'b0);
        compute_ref(tc);
        apb_write(nm, `NPU_REG_CTRL, 32'h1, 1'b0);
        if (tc.err) begin
            apb_write(nm, byte_addr(tc.src1), 32'hdead_beef, 1'b1);
            apb_read(nm, byte_addr(tc.dst), 1'b1, data);
            apb_write(nm, `NPU_REG_CTRL, 32'h1, 1'b1); // Second start
            st = status_of(1'b1, 1'b0, 1'b1);
        end else begin
            st = status_of(1'b1, 1'b0, 1'b0); // Previous done cleared
        end
        apb_read(nm, `NPU_REG_STATUS, 1'b0, data);
        check_status(nm, st, npu_pkg::npu_status_t'(data[2:0]));
        do begin
            apb_read(nm, `NPU_REG_STATUS, 1'b0, data);
            st = npu_pkg::npu_status_t'(data[2:0]);
        end while (st.busy);
        check_status(nm, status_of(1'b0, 1'b1, 1'b0), st);
        check_irq(nm, 1'b1, irq);
        for (int k = 0; k < `NPU_DIM * `NPU_DIM; k++) begin
            apb_read(nm, byte_addr(wrap_addr(tc.dst, k)), 1'b0, data);
            check_word(nm, exp_tile[k], data);
        end
        if (tc.err) begin
            apb_read(nm, byte_addr(tc.src1), 1'b0, data);
            check_word(nm, ref_mem[tc.src1], data); // Refused write left no trace
        end
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lcg_state = 32'd81;
        set_case(0, "rand_basic", 0, 9, 18, FILL_RAND, 1'b0);
        set_case(1, "identity", 3, 12, 21, FILL_IDENT, 1'b0);
        set_case(2, "all_ones", 20, 2, 11, FILL_ONES, 1'b0);
        set_case(3, "overlap_ab", 5, 8, 14, FILL_RAND, 1'b0);
        set_case(4, "wrap_top", 27, 30, 25, FILL_RAND, 1'b0);
        set_case(5, "dst_on_src", 10, 16, 10, FILL_RAND, 1'b0);
        set_case(6, "busy_refusal", 1, 12, 22, FILL_RAND, 1'b1);
        set_case(7, "same_region", 0, 0, 0, FILL_IDENT, 1'b0);
        repeat (8) @(posedge clk_50);
        @(negedge clk_50);
        rst = 1'b0;

        apb_read("reset_status", `NPU_REG_STATUS, 1'b0, rd);
        check_status("reset_status", status_of(1'b0, 1'b0, 1'b0),
                     npu_pkg::npu_status_t'(rd[2:0]));
        check_irq("reset_status", 1'b0, irq);
        for (int a = 0; a < `NPU_MEM_WORDS; a++) begin
            ref_mem[a] = lcg_next();
            apb_write("mem_fill", byte_addr(npu_pkg::npu_addr_t'(a)), ref_mem[a], 1'b0);
        end
        for (int a = 0; a < `NPU_MEM_WORDS; a++) begin
            apb_read("mem_readback", byte_addr(npu_pkg::npu_addr_t'(a)), 1'b0, rd);
            check_word("mem_readback", ref_mem[a], rd);
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        apb_write("unmapped", 12'h114, 32'h5, 1'b1);
        apb_read("unmapped", 12'h200, 1'b1, rd);
        apb_read("unmapped", `NPU_REG_STATUS, 1'b0, rd);
        check_status("unmapped", status_of(1'b0, 1'b1, 1'b1), npu_pkg::npu_status_t'(rd[2:0]));

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog/npu_apb_port.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_apb_port (
    input  logic                clk_50,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  npu_pkg::npu_word_t  pwdata,
    output npu_pkg::npu_word_t  prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                busy,
    input  logic                done,
    input  npu_pkg::npu_word_t  mem_rdata,
    output npu_pkg::npu_addr_t  host_raddr,
    output npu_pkg::npu_wr_t    host_wr,
    output npu_pkg::npu_cmd_t   cmd,
    output logic                irq
);

    logic access;
    logic wr_ok;
    logic is_mem, is_src1, is_src2, is_dst, is_ctrl, is_status;
    logic mapped;
    logic start_req;
    npu_pkg::npu_addr_t src1_q, src2_q, dst_q;
    logic done_q, error_q;
    npu_pkg::npu_status_t status;

    // ********************
    // Address decode
    // ********************
    assign access = psel & penable;
    assign is_mem = paddr < 12'(`NPU_MEM_WORDS * 4);
    assign is_src1 = paddr == `NPU_REG_SRC1;
    assign is_src2 = paddr == `NPU_REG_SRC2;
    assign is_dst = paddr == `NPU_REG_DST;
    assign is_ctrl = paddr == `NPU_REG_CTRL;
    assign is_status = paddr == `NPU_REG_STATUS;
    assign mapped = is_mem | is_src1 | is_src2 | is_dst | is_ctrl | is_status;

    assign start_req = is_ctrl & pwrite & pwdata[0];
    assign pslverr = access & (~mapped | (is_mem & busy) | (start_req & busy));
    assign wr_ok = access & pwrite & ~pslverr;
    assign pready = 1'b1; // Zero wait states

    assign host_raddr = paddr[`NPU_MEM_AW+1:2];
    assign host_wr.en = wr_ok & is_mem;
    assign host_wr.addr = paddr[`NPU_MEM_AW+1:2];
    assign host_wr.data = pwdata;

    assign cmd.src1 = src1_q;
    assign cmd.src2 = src2_q;
    assign cmd.dst = dst_q;
    assign cmd.start = wr_ok & start_req; // Same cycle as the access phase

    assign status.busy = busy;
    assign status.done = done_q;
    assign status.error = error_q;
    assign irq = done_q;

    always_comb begin
        prdata = '0;
        if (is_mem) begin
            prdata = mem_rdata;
        end else if (is_src1) begin
            prdata = 32'(src1_q);
        end else if (is_src2) begin
            prdata = 32'(src2_q);
        end else if (is_dst) begin
            prdata = 32'(dst_q);
        end else if (is_status) begin
            prdata = 32'(status);
        end
    end

    // ********************
    // Command and status registers
    // ********************
    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            src1_q <= '0;
            src2_q <= '0;
            dst_q <= '0;
            done_q <= 1'b0;
            error_q <= 1'b0;
        end else begin
            if (wr_ok && is_src1) src1_q <= pwdata[`NPU_MEM_AW-1:0];
            if (wr_ok && is_src2) src2_q <= pwdata[`NPU_MEM_AW-1:0];
            if (wr_ok && is_dst) dst_q <= pwdata[`NPU_MEM_AW-1:0];

            if (cmd.start) begin
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1; // Sticky until next start
            end

            if (pslverr) begin
                error_q <= 1'b1;
            end else if (access && !pwrite && is_status) begin
                error_q <= 1'b0; // Read to clear
            end
        end
    end

endmodule

// ==== verilog/npu_config.svh ====
`ifndef NPU_CONFIG_SVH
`define NPU_CONFIG_SVH

// ********************
// Scratch memory geometry
// ********************
`define NPU_MEM_WORDS 32
`define NPU_MEM_AW 5

// ********************
// Matrix engine
// ********************
`define NPU_DIM 3
`define NPU_STEPS 7 // 3*DIM-2 skewed steps

// ********************
// APB register map, byte addresses
// ********************
`define NPU_REG_SRC1 12'h100
`define NPU_REG_SRC2 12'h104
`define NPU_REG_DST 12'h108
`define NPU_REG_CTRL 12'h10C
`define NPU_REG_STATUS 12'h110

`endif

// ==== verilog/npu_operand_feeder.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_operand_feeder (
    input  logic                clk_50,
    input  logic                rst,
    input  npu_pkg::npu_cmd_t   cmd,
    input  logic                done,
    output logic                busy,
    output npu_pkg::npu_addr_t  eng_raddr [2*`NPU_DIM],
    input  npu_pkg::npu_word_t  eng_rdata [2*`NPU_DIM],
    output npu_pkg::npu_edge_t  array_edge,
    output logic                tile_ready,
    output npu_pkg::npu_addr_t  dst
);

    logic feeding;
    logic clear_q;
    logic [2:0] step;
    npu_pkg::npu_addr_t src1_q, src2_q, dst_q;

    assign dst = dst_q;

    // ********************
    // Step sequencing
    // ********************
    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            feeding <= 1'b0;
            clear_q <= 1'b0;
            tile_ready <= 1'b0;
            step <= '0;
        end else begin
            clear_q <= 1'b0;
            tile_ready <= 1'b0;
            if (cmd.start) begin
                busy <= 1'b1;
                feeding <= 1'b1;
                clear_q <= 1'b1; // Coincides with step 0
                step <= '0;
            end else if (feeding) begin
                if (step == 3'(`NPU_STEPS - 1)) begin
                    feeding <= 1'b0;
                    tile_ready <= 1'b1; // Leaves one cycle for the last PE
                end else begin
                    step <= step + 3'd1;
                end
            end
            if (done) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_50) begin
        if (cmd.start) begin
            src1_q <= cmd.src1;
            src2_q <= cmd.src2;
            dst_q <= cmd.dst;
        end
    end

    // ********************
    // Skewed fetch, lane l lags by l steps
    // ********************
    always_comb begin
        int k;
        array_edge = '0;
        array_edge.clear = clear_q;
        for (int l = 0; l < `NPU_DIM; l++) begin
            k = int'(step) - l;
            eng_raddr[l] = src1_q + npu_pkg::npu_addr_t'(`NPU_DIM * l + k); // A[l][k]
            eng_raddr[`NPU_DIM + l] = src2_q + npu_pkg::npu_addr_t'(`NPU_DIM * k + l); // B[k][l]
            if (feeding && k >= 0 && k < `NPU_DIM) begin
                array_edge.a[l] = eng_rdata[l];
                array_edge.b[l] = eng_rdata[`NPU_DIM + l];
            end
        end
    end

endmodule

// ==== verilog/npu_pe.sv ====
`timescale 1ns/1ns

module npu_pe (
    input  logic                clk_50,
    input  logic                rst,
    input  logic                clear,
    input  npu_pkg::npu_word_t  a_in,
    input  npu_pkg::npu_word_t  b_in,
    output npu_pkg::npu_word_t  a_out,
    output npu_pkg::npu_word_t  b_out,
    output npu_pkg::npu_word_t  acc
);

    npu_pkg::npu_word_t prod;

    assign prod = a_in * b_in; // Low 32 bits only

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            a_out <= '0;
            b_out <= '0;
            acc <= '0;
        end else begin
            a_out <= a_in; // To the right neighbour
            b_out <= b_in; // To the PE below
            acc <= (clear ? '0 : acc) + prod;
        end
    end

endmodule

// ==== verilog/npu_pkg.sv ====
`include "npu_config.svh"

package npu_pkg;

    typedef logic [31:0] npu_word_t;
    typedef logic [`NPU_MEM_AW-1:0] npu_addr_t; // Wraps modulo memory depth

    typedef struct packed {
        npu_addr_t src1;
        npu_addr_t src2;
        npu_addr_t dst;
        logic start; // One cycle pulse
    } npu_cmd_t;

    typedef struct packed {
        logic error; // Bit 2
        logic done;
        logic busy; // Bit 0
    } npu_status_t;

    typedef struct packed {
        logic en;
        npu_addr_t addr;
        npu_word_t data;
    } npu_wr_t;

    // Left edge feeds rows, top edge feeds columns
    typedef struct packed {
        npu_word_t [0:`NPU_DIM-1] a;
        npu_word_t [0:`NPU_DIM-1] b;
        logic clear;
    } npu_edge_t;

    typedef struct packed {
        npu_word_t [0:`NPU_DIM*`NPU_DIM-1] c; // Row-major
    } npu_tile_t;

endpackage

// ==== verilog/npu_result_writer.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_result_writer (
    input  logic                clk_50,
    input  logic                rst,
    input  logic                tile_ready,
    input  npu_pkg::npu_addr_t  dst,
    input  npu_pkg::npu_tile_t  tile,
    output npu_pkg::npu_wr_t    eng_wr,
    output logic                done
);

    localparam int unsigned LAST = `NPU_DIM * `NPU_DIM - 1;

    logic active;
    logic [3:0] idx;
    npu_pkg::npu_tile_t tile_q;
    npu_pkg::npu_addr_t dst_q;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            idx <= '0;
        end else if (tile_ready) begin
            active <= 1'b1;
            idx <= '0;
        end else if (active) begin
            if (idx == 4'(LAST)) begin
                active <= 1'b0;
            end else begin
                idx <= idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (tile_ready) begin
            tile_q <= tile; // Snapshot, array may keep running
            dst_q <= dst;
        end
    end

    // ********************
    // One word per cycle
    // ********************
    assign eng_wr.en = active;
    assign eng_wr.addr = dst_q + npu_pkg::npu_addr_t'(idx); // Wraps past the top
    assign eng_wr.data = tile_q.c[idx];
    assign done = active && (idx == 4'(LAST)); // With the last write

endmodule

// ==== verilog/npu_scratch_mem.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_scratch_mem (
    input  logic                clk_50,
    input  logic                rst,
    input  logic                busy,
    input  npu_pkg::npu_wr_t    host_wr,
    input  npu_pkg::npu_wr_t    eng_wr,
    input  npu_pkg::npu_addr_t  host_raddr,
    output npu_pkg::npu_word_t  host_rdata,
    input  npu_pkg::npu_addr_t  eng_raddr [2*`NPU_DIM],
    output npu_pkg::npu_word_t  eng_rdata [2*`NPU_DIM]
);

    npu_pkg::npu_word_t mem [`NPU_MEM_WORDS];
    npu_pkg::npu_wr_t wr;

    assign wr = busy ? eng_wr : host_wr; // Engine owns the port while busy

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NPU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ********************
    // Asynchronous read ports
    // ********************
    assign host_rdata = mem[host_raddr];

    generate
        for (genvar p = 0; p < 2 * `NPU_DIM; p++) begin : g_eng_rd
            assign eng_rdata[p] = mem[eng_raddr[p]];
        end
    endgenerate

endmodule

// ==== verilog/npu_systolic_array.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_systolic_array (
    input  logic                clk_50,
    input  logic                rst,
    input  npu_pkg::npu_edge_t  array_edge,
    output npu_pkg::npu_tile_t  tile
);

    // Extra column and row hold the outputs of the far edge PEs
    npu_pkg::npu_word_t a_bus [`NPU_DIM][`NPU_DIM+1];
    npu_pkg::npu_word_t b_bus [`NPU_DIM+1][`NPU_DIM];
    npu_pkg::npu_word_t acc [`NPU_DIM*`NPU_DIM];

    generate
        for (genvar i = 0; i < `NPU_DIM; i++) begin : g_edge
            assign a_bus[i][0] = array_edge.a[i];
            assign b_bus[0][i] = array_edge.b[i];
        end

        for (genvar r = 0; r < `NPU_DIM; r++) begin : g_row
            for (genvar c = 0; c < `NPU_DIM; c++) begin : g_col
                npu_pe i_npu_pe (
                    .clk_50 (clk_50),
                    .rst    (rst),
                    .clear  (array_edge.clear),
                    .a_in   (a_bus[r][c]),
                    .b_in   (b_bus[r][c]),
                    .a_out  (a_bus[r][c+1]),
                    .b_out  (b_bus[r+1][c]),
                    .acc    (acc[r*`NPU_DIM+c])
                );
            end
        end
    endgenerate

    always_comb begin
        for (int i = 0; i < `NPU_DIM * `NPU_DIM; i++) begin
            tile.c[i] = acc[i];
        end
    end

endmodule

// ==== verilog/npu_top.sv ====
`timescale 1ns/1ns
`include "npu_config.svh"

module npu_top (
    input  logic                clk_50,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  npu_pkg::npu_word_t  pwdata,
    output npu_pkg::npu_word_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                irq
);

    logic busy;
    logic done;
    logic tile_ready;
    npu_pkg::npu_cmd_t cmd;
    npu_pkg::npu_wr_t host_wr;
    npu_pkg::npu_wr_t eng_wr;
    npu_pkg::npu_addr_t host_raddr;
    npu_pkg::npu_addr_t dst;
    npu_pkg::npu_word_t host_rdata;
    npu_pkg::npu_addr_t eng_raddr [2*`NPU_DIM];
    npu_pkg::npu_word_t eng_rdata [2*`NPU_DIM];
    npu_pkg::npu_edge_t array_edge;
    npu_pkg::npu_tile_t tile;

    // ********************
    // Input side
    // ********************
    npu_apb_port i_npu_apb_port (
        .clk_50     (clk_50),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done       (done),
        .mem_rdata  (host_rdata),
        .host_raddr (host_raddr),
        .host_wr    (host_wr),
        .cmd        (cmd),
        .irq        (irq)
    );

    npu_scratch_mem i_npu_scratch_mem (
        .clk_50     (clk_50),
        .rst        (rst),
        .busy       (busy),
        .host_wr    (host_wr),
        .eng_wr     (eng_wr),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata),
        .eng_raddr  (eng_raddr),
        .eng_rdata  (eng_rdata)
    );

    // ********************
    // Processing
    // ********************
    npu_operand_feeder i_npu_operand_feeder (
        .clk_50     (clk_50),
        .rst        (rst),
        .cmd        (cmd),
        .done       (done),
        .busy       (busy),
        .eng_raddr  (eng_raddr),
        .eng_rdata  (eng_rdata),
        .array_edge (array_edge),
        .tile_ready (tile_ready),
        .dst        (dst)
    );

    npu_systolic_array i_npu_systolic_array (
        .clk_50     (clk_50),
        .rst        (rst),
        .array_edge (array_edge),
        .tile       (tile)
    );

    // ********************
    // Output side
    // ********************
    npu_result_writer i_npu_result_writer (
        .clk_50     (clk_50),
        .rst        (rst),
        .tile_ready (tile_ready),
        .dst        (dst),
        .tile       (tile),
        .eng_wr     (eng_wr),
        .done       (done)
    );

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/npu_pkg.sv
verilog/npu_apb_port.sv
verilog/npu_scratch_mem.sv
verilog/npu_operand_feeder.sv
verilog/npu_pe.sv
verilog/npu_systolic_array.sv
verilog/npu_result_writer.sv
verilog/npu_top.sv
bench/npu_tb.sv
